// ==== source/cache_be_pkg.sv ====
package cache_be_pkg;

   // Front-end and back-end words have the same width here.
   localparam int ADDR_W        = 16;
   localparam int DATA_W        = 32;
   localparam int NBYTES        = 4;
   localparam int NBYTES_W      = 2;
   localparam int WORD_OFFSET_W = 2;
   localparam int LINE_WORDS    = 4;
   localparam int BUF_DEPTH     = 4;
   localparam int WORD_ADDR_W   = ADDR_W - NBYTES_W;
   localparam int LINE_ADDR_W   = WORD_ADDR_W - WORD_OFFSET_W;

   typedef logic [WORD_ADDR_W-1:0]   word_addr_t;
   typedef logic [LINE_ADDR_W-1:0]   line_addr_t;
   typedef logic [WORD_OFFSET_W-1:0] word_off_t;
   typedef logic [DATA_W-1:0]        data_t;
   typedef logic [NBYTES-1:0]        strb_t;

   // Line refill states.
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_FETCH,
      RD_END
   } rd_state_t;

   // Single write transfer states.
   typedef enum logic {
      WR_IDLE,
      WR_BUSY
   } wr_state_t;

endpackage

// ==== source/cache_write_buffer.sv ====
`timescale 1ns/1ps

module cache_write_buffer (
   input  logic                     clk,
   input  logic                     arst_n,

   input  logic                     buf_valid,
   input  cache_be_pkg::word_addr_t buf_addr,
   input  cache_be_pkg::data_t      buf_wdata,
   input  cache_be_pkg::strb_t      buf_wstrb,
   output logic                     buf_full,

   output logic                     write_valid,
   output cache_be_pkg::word_addr_t write_addr,
   output cache_be_pkg::data_t      write_wdata,
   output cache_be_pkg::strb_t      write_wstrb,
   input  logic                     write_ready,
   output logic                     write_empty
);

   cache_be_pkg::word_addr_t addr_mem [cache_be_pkg::BUF_DEPTH];
   cache_be_pkg::data_t      data_mem [cache_be_pkg::BUF_DEPTH];
   cache_be_pkg::strb_t      strb_mem [cache_be_pkg::BUF_DEPTH];

   logic [$clog2(cache_be_pkg::BUF_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(cache_be_pkg::BUF_DEPTH)-1:0]   rd_ptr;
   logic [$clog2(cache_be_pkg::BUF_DEPTH+1)-1:0] count;

   logic push;
   logic pop;

   // A push into a full buffer is dropped.
   assign push = buf_valid && !buf_full;
   assign pop  = write_valid && write_ready;

   assign buf_full    = (count == cache_be_pkg::BUF_DEPTH);
   assign write_empty = (count == 0);
   assign write_valid = !write_empty;

   // The head entry is always presented to the back end.
   assign write_addr  = addr_mem[rd_ptr];
   assign write_wdata = data_mem[rd_ptr];
   assign write_wstrb = strb_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         addr_mem[wr_ptr] <= buf_addr;
         data_mem[wr_ptr] <= buf_wdata;
         strb_mem[wr_ptr] <= buf_wstrb;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == cache_be_pkg::BUF_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == cache_be_pkg::BUF_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   // Simultaneous push and pop leave the occupancy unchanged.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== source/cache_write_channel.sv ====
`timescale 1ns/1ps

module cache_write_channel (
   input  logic                     clk,
   input  logic                     arst_n,

   input  logic                     valid,
   input  cache_be_pkg::word_addr_t addr,
   input  cache_be_pkg::data_t      wdata,
   input  cache_be_pkg::strb_t      wstrb,
   output logic                     ready,

   output logic                     mem_valid,
   output cache_be_pkg::word_addr_t mem_addr,
   output cache_be_pkg::data_t      mem_wdata,
   output cache_be_pkg::strb_t      mem_wstrb,
   input  logic                     mem_ready,

   output logic                     idle
);

   cache_be_pkg::wr_state_t state;
   cache_be_pkg::wr_state_t state_nxt;

   cache_be_pkg::word_addr_t addr_q;
   cache_be_pkg::data_t      wdata_q;
   cache_be_pkg::strb_t      wstrb_q;

   logic accept;
   logic busy;

   assign busy   = (state == cache_be_pkg::WR_BUSY);
   assign idle   = (state == cache_be_pkg::WR_IDLE);
   assign ready  = idle;
   assign accept = valid && ready;

   always_comb begin
      state_nxt = state;
      case (state)
         cache_be_pkg::WR_IDLE: begin
            if (accept) begin
               state_nxt = cache_be_pkg::WR_BUSY;
            end
         end
         cache_be_pkg::WR_BUSY: begin
            // Hold the word on the port until memory takes it.
            if (mem_ready) begin
               state_nxt = cache_be_pkg::WR_IDLE;
            end
         end
         default: state_nxt = cache_be_pkg::WR_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= cache_be_pkg::WR_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= addr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
   end

   assign mem_valid = busy;
   assign mem_addr  = addr_q;
   assign mem_wdata = wdata_q;

   // The strobes are zeroed when idle, since a zero strobe marks a read
   // while the refill channel owns the port.
   assign mem_wstrb = busy ? wstrb_q : '0;

endmodule

// ==== source/cache_read_channel.sv ====
`timescale 1ns/1ps

module cache_read_channel (
   input  logic                     clk,
   input  logic                     arst_n,

   input  logic                     replace_valid,
   input  cache_be_pkg::line_addr_t replace_addr,
   input  logic                     start_ok,
   output logic                     replace,
   output logic                     read_valid,
   output cache_be_pkg::word_off_t  read_addr,
   output cache_be_pkg::data_t      read_rdata,

   output logic                     mem_valid,
   output cache_be_pkg::word_addr_t mem_addr,
   input  cache_be_pkg::data_t      mem_rdata,
   input  logic                     mem_ready
);

   cache_be_pkg::rd_state_t state;
   cache_be_pkg::rd_state_t state_nxt;

   cache_be_pkg::line_addr_t line_q;
   cache_be_pkg::word_off_t  word_cnt;

   logic start;
   logic fetch;
   logic last_word;

   assign fetch     = (state == cache_be_pkg::RD_FETCH);
   assign start     = (state == cache_be_pkg::RD_IDLE) && replace_valid && start_ok;
   assign last_word = (word_cnt == cache_be_pkg::word_off_t'(cache_be_pkg::LINE_WORDS - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         cache_be_pkg::RD_IDLE: begin
            if (start) begin
               state_nxt = cache_be_pkg::RD_FETCH;
            end
         end
         cache_be_pkg::RD_FETCH: begin
            if (mem_ready && last_word) begin
               state_nxt = cache_be_pkg::RD_END;
            end
         end
         // One quiet cycle lets the requester see replace fall.
         cache_be_pkg::RD_END: begin
            state_nxt = cache_be_pkg::RD_IDLE;
         end
         default: state_nxt = cache_be_pkg::RD_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= cache_be_pkg::RD_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         word_cnt <= '0;
      end else if (start) begin
         word_cnt <= '0;
      end else if (fetch && mem_ready) begin
         word_cnt <= word_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         line_q <= replace_addr;
      end
   end

   assign replace   = fetch;
   assign mem_valid = fetch;
   assign mem_addr  = {line_q, word_cnt};

   // Each returned word goes straight back with its offset in the line.
   assign read_valid = fetch && mem_ready;
   assign read_addr  = word_cnt;
   assign read_rdata = mem_rdata;

endmodule

// ==== source/cache_back_end.sv ====
`timescale 1ns/1ps

module cache_back_end (
   input  logic                     clk,
   input  logic                     arst_n,

   input  logic                     write_valid,
   input  cache_be_pkg::word_addr_t write_addr,
   input  cache_be_pkg::data_t      write_wdata,
   input  cache_be_pkg::strb_t      write_wstrb,
   output logic                     write_ready,
   input  logic                     write_empty,

   input  logic                     replace_valid,
   input  cache_be_pkg::line_addr_t replace_addr,
   output logic                     replace,
   output logic                     read_valid,
   output cache_be_pkg::word_off_t  read_addr,
   output cache_be_pkg::data_t      read_rdata,

   output logic                     mem_valid,
   output cache_be_pkg::word_addr_t mem_addr,
   output cache_be_pkg::data_t      mem_wdata,
   output cache_be_pkg::strb_t      mem_wstrb,
   input  cache_be_pkg::data_t      mem_rdata,
   input  logic                     mem_ready
);

   cache_be_pkg::word_addr_t mem_addr_read;
   cache_be_pkg::word_addr_t mem_addr_write;
   logic mem_valid_read;
   logic mem_valid_write;
   logic write_idle;
   logic write_ready_fsm;
   logic start_ok;

   // A refill waits until every earlier write has left the buffer and the port.
   assign start_ok = write_empty && write_idle;

   // Writes are held off for the whole refill. Ready is masked as well so
   // the buffer does not pop a word the channel never took.
   assign write_ready = write_ready_fsm && !replace;

   assign mem_valid = mem_valid_read | mem_valid_write;
   assign mem_addr  = mem_valid_read ? mem_addr_read : mem_addr_write;

   cache_read_channel read_fsm (
      .clk           (clk),
      .arst_n        (arst_n),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .start_ok      (start_ok),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .mem_valid     (mem_valid_read),
      .mem_addr      (mem_addr_read),
      .mem_rdata     (mem_rdata),
      .mem_ready     (mem_ready)
   );

   cache_write_channel write_fsm (
      .clk       (clk),
      .arst_n    (arst_n),
      .valid     (write_valid && !replace),
      .addr      (write_addr),
      .wdata     (write_wdata),
      .wstrb     (write_wstrb),
      .ready     (write_ready_fsm),
      .mem_valid (mem_valid_write),
      .mem_addr  (mem_addr_write),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_ready (mem_ready),
      .idle      (write_idle)
   );

endmodule

// ==== source/cache_be_subsystem.sv ====
`timescale 1ns/1ps

module cache_be_subsystem (
   input  logic                     clk,
   input  logic                     arst_n,

   input  logic                     buf_valid,
   input  cache_be_pkg::word_addr_t buf_addr,
   input  cache_be_pkg::data_t      buf_wdata,
   input  cache_be_pkg::strb_t      buf_wstrb,
   output logic                     buf_full,

   input  logic                     replace_valid,
   input  cache_be_pkg::line_addr_t replace_addr,
   output logic                     replace,
   output logic                     read_valid,
   output cache_be_pkg::word_off_t  read_addr,
   output cache_be_pkg::data_t      read_rdata,

   output logic                     mem_valid,
   output cache_be_pkg::word_addr_t mem_addr,
   output cache_be_pkg::data_t      mem_wdata,
   output cache_be_pkg::strb_t      mem_wstrb,
   input  cache_be_pkg::data_t      mem_rdata,
   input  logic                     mem_ready
);

   logic                     write_valid;
   cache_be_pkg::word_addr_t write_addr;
   cache_be_pkg::data_t      write_wdata;
   cache_be_pkg::strb_t      write_wstrb;
   logic                     write_ready;
   logic                     write_empty;

   cache_write_buffer wbuf_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .buf_valid   (buf_valid),
      .buf_addr    (buf_addr),
      .buf_wdata   (buf_wdata),
      .buf_wstrb   (buf_wstrb),
      .buf_full    (buf_full),
      .write_valid (write_valid),
      .write_addr  (write_addr),
      .write_wdata (write_wdata),
      .write_wstrb (write_wstrb),
      .write_ready (write_ready),
      .write_empty (write_empty)
   );

   cache_back_end back_end_i (
      .clk           (clk),
      .arst_n        (arst_n),
      .write_valid   (write_valid),
      .write_addr    (write_addr),
      .write_wdata   (write_wdata),
      .write_wstrb   (write_wstrb),
      .write_ready   (write_ready),
      .write_empty   (write_empty),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .mem_valid     (mem_valid),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .mem_wstrb     (mem_wstrb),
      .mem_rdata     (mem_rdata),
      .mem_ready     (mem_ready)
   );

endmodule

// ==== tb/be_mem_model.sv ====
`timescale 1ns/1ps

module be_mem_model (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     mem_valid,
   input  cache_be_pkg::word_addr_t mem_addr,
   input  cache_be_pkg::data_t      mem_wdata,
   input  cache_be_pkg::strb_t      mem_wstrb,
   output cache_be_pkg::data_t      mem_rdata,
   output logic                     mem_ready
);

   localparam int MAX_DELAY = 3;
   localparam int DEPTH     = 2 ** cache_be_pkg::WORD_ADDR_W;

   cache_be_pkg::data_t mem [DEPTH];

   int unsigned delay;
   int unsigned waited;

   // Every word starts as a pattern built from its own address.
   initial begin
      for (int a = 0; a < DEPTH; a++) begin
         mem[a] = {2'b10, cache_be_pkg::word_addr_t'(a), 2'b01,
                   cache_be_pkg::word_addr_t'(a) ^ 14'h2aaa};
      end
   end

   assign mem_ready = mem_valid && (waited == delay);
   assign mem_rdata = mem[mem_addr];

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         delay  <= 0;
         waited <= 0;
      end else if (mem_ready) begin
         waited <= 0;
         delay  <= $urandom_range(MAX_DELAY, 0);
      end else if (mem_valid) begin
         waited <= waited + 1;
      end
   end

   // A zero strobe is a read and leaves the word alone.
   always @(posedge clk) begin
      if (mem_ready) begin
         for (int i = 0; i < cache_be_pkg::NBYTES; i++) begin
            if (mem_wstrb[i]) begin
               mem[mem_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
            end
         end
      end
   end

endmodule

// ==== tb/cache_be_tb.sv ====
`timescale 1ns/1ps

module cache_be_tb;

   localparam int      CLK_PERIOD    = 4;
   localparam realtime DRIVE_DLY     = 0.5;
   localparam int      SEED          = 32'h3f1c;
   localparam int      NUM_OPS       = 13;
   localparam int      CYCLES_PER_OP = 40;

   typedef enum logic [1:0] {
      OP_WRITE,
      OP_REFILL,
      OP_BURST
   } op_kind_t;

   typedef struct packed {
      op_kind_t                 kind;
      cache_be_pkg::word_addr_t addr;
      cache_be_pkg::data_t      data;
      cache_be_pkg::strb_t      strb;
      logic [3:0]               len;
   } op_t;

   // A refill takes its line from the low bits of addr. A burst writes len words
   // from addr on, wrapping inside the line, with the data counting up.
   // A refill with a nonzero strobe also pushes data to word addr while replace
   // is high. That word sits in another line, which a later refill reads back.
   localparam op_t OPS [NUM_OPS] = '{
      '{OP_REFILL, 14'h0010, 32'h0000_0000, 4'h0, 4'd0},
      '{OP_WRITE,  14'h0081, 32'hdead_beef, 4'h6, 4'd1},
      '{OP_REFILL, 14'h0020, 32'h0000_0000, 4'h0, 4'd0},
      '{OP_BURST,  14'h00c0, 32'h1122_3344, 4'hf, 4'd4},
      '{OP_REFILL, 14'h0030, 32'h0000_0000, 4'h0, 4'd0},
      '{OP_BURST,  14'h0100, 32'h5a00_0000, 4'hf, 4'd8},
      '{OP_REFILL, 14'h0040, 32'h0000_0000, 4'h0, 4'd0},
      '{OP_WRITE,  14'h0102, 32'hcafe_f00d, 4'h8, 4'd1},
      '{OP_BURST,  14'h0142, 32'h0000_a5a0, 4'h3, 4'd8},
      '{OP_REFILL, 14'h0050, 32'h0000_0000, 4'h0, 4'd0},
      '{OP_REFILL, 14'h0040, 32'h6b1d_29c4, 4'h5, 4'd0},
      '{OP_REFILL, 14'h0010, 32'h0000_0000, 4'h0, 4'd0},
      '{OP_REFILL, 14'h0fff, 32'h0000_0000, 4'h0, 4'd0}
   };

   logic                     clk;
   logic                     arst_n;
   logic                     buf_valid;
   cache_be_pkg::word_addr_t buf_addr;
   cache_be_pkg::data_t      buf_wdata;
   cache_be_pkg::strb_t      buf_wstrb;
   logic                     buf_full;
   logic                     replace_valid;
   cache_be_pkg::line_addr_t replace_addr;
   logic                     replace;
   logic                     read_valid;
   cache_be_pkg::word_off_t  read_addr;
   cache_be_pkg::data_t      read_rdata;
   logic                     mem_valid;
   cache_be_pkg::word_addr_t mem_addr;
   cache_be_pkg::data_t      mem_wdata;
   cache_be_pkg::strb_t      mem_wstrb;
   cache_be_pkg::data_t      mem_rdata;
   logic                     mem_ready;

   // Expected memory contents, only for words that have been written.
   cache_be_pkg::data_t shadow [cache_be_pkg::word_addr_t];
   logic                saw_full;

   cache_be_subsystem dut_i (.*);

   be_mem_model mem_i (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic value_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
      fail_run($sformatf("FAIL time %0t %s expected %h actual %h", $time, name, exp, act));
   endtask

   task automatic next_drive();
      @(posedge clk);
      #(DRIVE_DLY);
   endtask

   function automatic cache_be_pkg::data_t expected_word(input cache_be_pkg::word_addr_t a);
      if (shadow.exists(a)) begin
         return shadow[a];
      end
      return {2'b10, a, 2'b01, a ^ 14'h2aaa};
   endfunction

   // Called at a drive point. The push waits while the buffer is full.
   task automatic push_write(input cache_be_pkg::word_addr_t a, input cache_be_pkg::data_t d,
                             input cache_be_pkg::strb_t s);
      cache_be_pkg::data_t w;
      while (buf_full) begin
         saw_full = 1'b1;
         next_drive();
      end
      buf_valid = 1'b1;
      buf_addr  = a;
      buf_wdata = d;
      buf_wstrb = s;
      w = expected_word(a);
      for (int i = 0; i < cache_be_pkg::NBYTES; i++) begin
         if (s[i]) begin
            w[8*i +: 8] = d[8*i +: 8];
         end
      end
      shadow[a] = w;
      next_drive();
      buf_valid = 1'b0;
   endtask

   // The optional side write is pushed once replace is high, so it has to
   // wait in the buffer until the refill is over.
   task automatic refill_line(input cache_be_pkg::line_addr_t line, input logic side_en,
                              input cache_be_pkg::word_addr_t side_addr,
                              input cache_be_pkg::data_t side_data,
                              input cache_be_pkg::strb_t side_strb);
      cache_be_pkg::word_addr_t wa;
      logic started;
      logic done;
      int   words;
      started = 1'b0;
      done    = 1'b0;
      words   = 0;
      replace_valid = 1'b1;
      replace_addr  = line;
      fork
         begin
            while (!done) begin
               @(negedge clk);
               if (read_valid) begin
                  assert (words < cache_be_pkg::LINE_WORDS)
                     else fail_run($sformatf("Refill of line %h returned more than four words",
                                             line));
                  wa = {line, cache_be_pkg::word_off_t'(words)};
                  assert (read_addr == cache_be_pkg::word_off_t'(words))
                     else value_mismatch("read_addr", 32'(words), 32'(read_addr));
                  assert (read_rdata == expected_word(wa))
                     else value_mismatch("read_rdata", expected_word(wa), read_rdata);
                  words++;
               end
               if (replace) begin
                  started = 1'b1;
               end else if (started) begin
                  done = 1'b1;
               end
            end
            assert (words == cache_be_pkg::LINE_WORDS)
               else fail_run($sformatf("Refill of line %h returned %0d words", line, words));
            next_drive();
            replace_valid = 1'b0;
         end
         begin
            if (side_en) begin
               while (!replace) begin
                  next_drive();
               end
               push_write(side_addr, side_data, side_strb);
            end
         end
      join
   endtask

   // The refill owns the port, so no write strobe may show up then.
   always @(negedge clk) begin
      if (arst_n) begin
         if (replace) begin
            assert (mem_wstrb == '0) else value_mismatch("mem_wstrb", 32'h0, 32'(mem_wstrb));
         end
         assert (!read_valid || replace) else fail_run("read_valid pulsed outside a refill");
      end
   end

   initial begin
      #(NUM_OPS * CYCLES_PER_OP * CLK_PERIOD);
      $display("Timeout after %0d cycles with the table still running", NUM_OPS * CYCLES_PER_OP);
      $display("Testbench failed");
      $fatal(1);
   end

   initial begin
      op_t op;
      void'($urandom(SEED));
      clk           = 1'b0;
      arst_n        = 1'b0;
      buf_valid     = 1'b0;
      buf_addr      = '0;
      buf_wdata     = '0;
      buf_wstrb     = '0;
      replace_valid = 1'b0;
      replace_addr  = '0;
      saw_full      = 1'b0;
      repeat (2) @(posedge clk);
      #(DRIVE_DLY);
      arst_n = 1'b1;
      @(negedge clk);
      assert (!replace) else value_mismatch("replace", 32'h0, 32'(replace));
      assert (!read_valid) else value_mismatch("read_valid", 32'h0, 32'(read_valid));
      assert (!mem_valid) else value_mismatch("mem_valid", 32'h0, 32'(mem_valid));
      assert (!buf_full) else value_mismatch("buf_full", 32'h0, 32'(buf_full));
      next_drive();
      for (int n = 0; n < NUM_OPS; n++) begin
         op = OPS[n];
         case (op.kind)
            OP_WRITE:  push_write(op.addr, op.data, op.strb);
            OP_REFILL: refill_line(op.addr[cache_be_pkg::LINE_ADDR_W-1:0], op.strb != '0,
                                   op.addr, op.data, op.strb);
            OP_BURST: begin
               for (int k = 0; k < int'(op.len); k++) begin
                  push_write({op.addr[cache_be_pkg::WORD_ADDR_W-1:cache_be_pkg::WORD_OFFSET_W],
                              cache_be_pkg::word_off_t'(op.addr[1:0] + k)},
                             op.data + 32'(k), op.strb);
               end
            end
            default: fail_run("Unknown operation kind in the table");
         endcase
      end
      assert (saw_full) else fail_run("buf_full never rose during the long bursts");
      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== sim.f ====
source/cache_be_pkg.sv
source/cache_write_buffer.sv
source/cache_write_channel.sv
source/cache_read_channel.sv
source/cache_back_end.sv
source/cache_be_subsystem.sv
tb/be_mem_model.sv
tb/cache_be_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module cache_be_tb -Mdir obj_dir \
   -f sim.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vcache_be_tb > sim.log 2>&1
cat sim.log
grep -qx "Testbench passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
